/* vec_backend_cfg.svh */
`ifndef VEC_BACKEND_CFG_SVH
`define VEC_BACKEND_CFG_SVH

// Datapath widths
`define VLEN            64
`define ELEN            8
`define NUM_VREG        32
`define VREG_IDX_W      5

// Buffer depths
`define CQ_DEPTH        4
`define ROB_DEPTH       4

// OPIVV funct6 encodings
`define FUNCT6_VADD     6'b000000
`define FUNCT6_VSUB     6'b000010
`define FUNCT6_VAND     6'b001001
`define FUNCT6_VSADDU   6'b100000

// Major opcode and funct3
`define OPCODE_OPV      7'b1010111
`define FUNCT3_OPIVV    3'b000

`endif

/* vec_backend_pkg.sv */
`include "vec_backend_cfg.svh"

package vec_backend_pkg;

    // Raw instruction word from the scalar core
    typedef logic [31:0] inst_t;

    // Vector register index
    typedef logic [`VREG_IDX_W-1:0] vreg_idx_t;

    // Full vector register
    typedef logic [`VLEN-1:0] vreg_data_t;

    // Operation selected by decode
    typedef enum logic [2:0] {
        ALU_ADD     = 3'd0,
        ALU_SUB     = 3'd1,
        ALU_AND     = 3'd2,
        ALU_SADDU   = 3'd3,
        ALU_ILLEGAL = 3'd7
    } alu_op_t;

endpackage

/* vec_cmd_queue.sv */
`timescale 1ns/100ps
`include "vec_backend_cfg.svh"

module vec_cmd_queue (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_valid,
    input  vec_backend_pkg::inst_t inst,
    output logic                   inst_ready,
    output logic                   cq_valid,
    output vec_backend_pkg::inst_t cq_inst,
    input  logic                   cq_ready
);

    localparam int PTR_W = $clog2(`CQ_DEPTH);
    localparam int CNT_W = $clog2(`CQ_DEPTH + 1);

    vec_backend_pkg::inst_t mem [`CQ_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   push;
    logic                   pop;

    assign inst_ready = (count != CNT_W'(`CQ_DEPTH));
    assign cq_valid   = (count != '0);
    assign cq_inst    = mem[rd_ptr];

    assign push = inst_valid && inst_ready;
    assign pop  = cq_valid && cq_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= inst;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`CQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(`CQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Occupancy stays within the storage
    assert property (@(posedge clk) disable iff (!rst_n) count <= CNT_W'(`CQ_DEPTH));

endmodule

/* vec_dispatch.sv */
`timescale 1ns/100ps
`include "vec_backend_cfg.svh"

module vec_dispatch (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        cq_valid,
    input  vec_backend_pkg::inst_t      cq_inst,
    output logic                        cq_ready,
    output vec_backend_pkg::vreg_idx_t  rd_idx_a,
    output vec_backend_pkg::vreg_idx_t  rd_idx_b,
    input  vec_backend_pkg::vreg_data_t rd_data_a,
    input  vec_backend_pkg::vreg_data_t rd_data_b,
    output logic                        ex_valid,
    output vec_backend_pkg::alu_op_t    ex_op,
    output vec_backend_pkg::vreg_idx_t  ex_vd,
    output vec_backend_pkg::vreg_data_t ex_src_a,
    output vec_backend_pkg::vreg_data_t ex_src_b,
    input  logic                        ex_ready,
    input  logic                        wr_en,
    input  vec_backend_pkg::vreg_idx_t  wr_vd
);

    vec_backend_pkg::vreg_idx_t vs1;
    vec_backend_pkg::vreg_idx_t vs2;
    vec_backend_pkg::vreg_idx_t vd;
    logic [`NUM_VREG-1:0]       pending;
    logic                       legal;
    logic                       conflict;
    logic                       issue;

    assign vs2 = cq_inst[24:20];
    assign vs1 = cq_inst[19:15];
    assign vd  = cq_inst[11:7];

    always_comb begin
        ex_op = vec_backend_pkg::ALU_ILLEGAL;
        if (cq_inst[6:0] == `OPCODE_OPV && cq_inst[14:12] == `FUNCT3_OPIVV) begin
            case (cq_inst[31:26])
                `FUNCT6_VADD:   ex_op = vec_backend_pkg::ALU_ADD;
                `FUNCT6_VSUB:   ex_op = vec_backend_pkg::ALU_SUB;
                `FUNCT6_VAND:   ex_op = vec_backend_pkg::ALU_AND;
                `FUNCT6_VSADDU: ex_op = vec_backend_pkg::ALU_SADDU;
                default:        ex_op = vec_backend_pkg::ALU_ILLEGAL;
            endcase
        end
    end

    // Illegal words touch no register, so they never wait
    assign legal    = (ex_op != vec_backend_pkg::ALU_ILLEGAL);
    assign conflict = legal && (pending[vs1] || pending[vs2] || pending[vd]);

    // vs2 is the minuend for vsub
    assign rd_idx_a = vs2;
    assign rd_idx_b = vs1;
    assign ex_src_a = rd_data_a;
    assign ex_src_b = rd_data_b;
    assign ex_vd    = vd;

    assign ex_valid = cq_valid && !conflict;
    assign cq_ready = ex_ready && !conflict;
    assign issue    = ex_valid && ex_ready;

    // Clear on retire first, a new issue then claims its vd
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= '0;
        end else begin
            if (wr_en) begin
                pending[wr_vd] <= 1'b0;
            end
            if (issue && legal) begin
                pending[vd] <= 1'b1;
            end
        end
    end

    // Operands come only from retired state
    assert property (@(posedge clk) disable iff (!rst_n)
        issue && legal |-> !pending[vs1] && !pending[vs2]);

endmodule

/* vec_vrf.sv */
`timescale 1ns/100ps
`include "vec_backend_cfg.svh"

module vec_vrf (
    input  logic                        clk,
    input  logic                        rst_n,
    input  vec_backend_pkg::vreg_idx_t  rd_idx_a,
    input  vec_backend_pkg::vreg_idx_t  rd_idx_b,
    output vec_backend_pkg::vreg_data_t rd_data_a,
    output vec_backend_pkg::vreg_data_t rd_data_b,
    input  logic                        wr_en,
    input  vec_backend_pkg::vreg_idx_t  wr_vd,
    input  vec_backend_pkg::vreg_data_t wr_data
);

    localparam int LANES = `VLEN / `ELEN;

    vec_backend_pkg::vreg_data_t vreg [`NUM_VREG];

    // Asynchronous read ports
    assign rd_data_a = vreg[rd_idx_a];
    assign rd_data_b = vreg[rd_idx_b];

    // Every byte of register i starts as i
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `NUM_VREG; i++) begin
                vreg[i] <= {LANES{i[`ELEN-1:0]}};
            end
        end else if (wr_en) begin
            vreg[wr_vd] <= wr_data;
        end
    end

endmodule

/* vec_alu.sv */
`timescale 1ns/100ps
`include "vec_backend_cfg.svh"

module vec_alu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ex_valid,
    input  vec_backend_pkg::alu_op_t    ex_op,
    input  vec_backend_pkg::vreg_idx_t  ex_vd,
    input  vec_backend_pkg::vreg_data_t ex_src_a,
    input  vec_backend_pkg::vreg_data_t ex_src_b,
    output logic                        ex_ready,
    output logic                        res_valid,
    output vec_backend_pkg::vreg_idx_t  res_vd,
    output vec_backend_pkg::vreg_data_t res_data,
    output logic [1:0]                  res_vxsat,
    output logic                        res_illegal,
    input  logic                        res_ready
);

    localparam int LANES = `VLEN / `ELEN;

    vec_backend_pkg::vreg_data_t data_next;
    logic                        sat_next;
    logic [`ELEN-1:0]            lane_a;
    logic [`ELEN-1:0]            lane_b;
    logic [`ELEN:0]              lane_sum;

    always_comb begin
        data_next = '0;
        sat_next  = 1'b0;
        for (int l = 0; l < LANES; l++) begin
            lane_a   = ex_src_a[l*`ELEN +: `ELEN];
            lane_b   = ex_src_b[l*`ELEN +: `ELEN];
            lane_sum = {1'b0, lane_a} + {1'b0, lane_b};
            case (ex_op)
                vec_backend_pkg::ALU_ADD: data_next[l*`ELEN +: `ELEN] = lane_sum[`ELEN-1:0];
                vec_backend_pkg::ALU_SUB: data_next[l*`ELEN +: `ELEN] = lane_a - lane_b;
                vec_backend_pkg::ALU_AND: data_next[l*`ELEN +: `ELEN] = lane_a & lane_b;
                vec_backend_pkg::ALU_SADDU: begin
                    // Carry out means the lane clamps
                    if (lane_sum[`ELEN]) begin
                        data_next[l*`ELEN +: `ELEN] = '1;
                        sat_next = 1'b1;
                    end else begin
                        data_next[l*`ELEN +: `ELEN] = lane_sum[`ELEN-1:0];
                    end
                end
                default: data_next[l*`ELEN +: `ELEN] = '0;
            endcase
        end
    end

    // Output register can refill in the cycle it drains
    assign ex_ready = !res_valid || res_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else if (ex_ready) begin
            res_valid <= ex_valid;
        end
    end

    // Bit 1 marks a vxsat update, bit 0 carries the flag
    always_ff @(posedge clk) begin
        if (ex_valid && ex_ready) begin
            res_vd      <= ex_vd;
            res_data    <= data_next;
            res_vxsat   <= {ex_op == vec_backend_pkg::ALU_SADDU, sat_next};
            res_illegal <= (ex_op == vec_backend_pkg::ALU_ILLEGAL);
        end
    end

    // Dispatch keeps an offered operation steady until it is taken
    assert property (@(posedge clk) disable iff (!rst_n)
        ex_valid && !ex_ready |=> ex_valid && $stable(ex_op) && $stable(ex_vd));

endmodule

/* vec_rob.sv */
`timescale 1ns/100ps
`include "vec_backend_cfg.svh"

module vec_rob (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        res_valid,
    input  vec_backend_pkg::vreg_idx_t  res_vd,
    input  vec_backend_pkg::vreg_data_t res_data,
    input  logic [1:0]                  res_vxsat,
    input  logic                        res_illegal,
    output logic                        res_ready,
    output logic                        rt_valid,
    output vec_backend_pkg::vreg_idx_t  rt_vd,
    output vec_backend_pkg::vreg_data_t rt_data,
    output logic                        rt_illegal,
    input  logic                        rt_ready,
    output logic                        wr_vxsat_valid,
    output logic                        wr_vxsat,
    output logic                        wr_en,
    output vec_backend_pkg::vreg_idx_t  wr_vd,
    output vec_backend_pkg::vreg_data_t wr_data
);

    localparam int PTR_W = $clog2(`ROB_DEPTH);
    localparam int CNT_W = $clog2(`ROB_DEPTH + 1);

    vec_backend_pkg::vreg_idx_t  vd_q      [`ROB_DEPTH];
    vec_backend_pkg::vreg_data_t data_q    [`ROB_DEPTH];
    logic [1:0]                  vxsat_q   [`ROB_DEPTH];
    logic                        illegal_q [`ROB_DEPTH];
    logic [PTR_W-1:0]            wr_ptr;
    logic [PTR_W-1:0]            rd_ptr;
    logic [CNT_W-1:0]            count;
    logic                        full;
    logic                        push;
    logic                        retire;

    assign full      = (count == CNT_W'(`ROB_DEPTH));
    assign res_ready = !full;
    assign push      = res_valid && res_ready;

    // Head entry drives the retire port
    assign rt_valid   = (count != '0);
    assign rt_vd      = vd_q[rd_ptr];
    assign rt_data    = data_q[rd_ptr];
    assign rt_illegal = illegal_q[rd_ptr];
    assign retire     = rt_valid && rt_ready;

    assign wr_en          = retire && !illegal_q[rd_ptr];
    assign wr_vd          = vd_q[rd_ptr];
    assign wr_data        = data_q[rd_ptr];
    assign wr_vxsat_valid = retire && vxsat_q[rd_ptr][1];
    assign wr_vxsat       = vxsat_q[rd_ptr][0];

    always_ff @(posedge clk) begin
        if (push) begin
            vd_q[wr_ptr]      <= res_vd;
            data_q[wr_ptr]    <= res_data;
            vxsat_q[wr_ptr]   <= res_vxsat;
            illegal_q[wr_ptr] <= res_illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(`ROB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (retire) begin
                rd_ptr <= (rd_ptr == PTR_W'(`ROB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !retire) begin
                count <= count + 1'b1;
            end else if (retire && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Full buffer refuses the ALU, which keeps its result
    assert property (@(posedge clk) disable iff (!rst_n)
        full && res_valid |-> !res_ready ##1 res_valid);

endmodule

/* vec_backend.sv */
`timescale 1ns/100ps

module vec_backend (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        inst_valid,
    input  vec_backend_pkg::inst_t      inst,
    output logic                        inst_ready,
    output logic                        rt_valid,
    output vec_backend_pkg::vreg_idx_t  rt_vd,
    output vec_backend_pkg::vreg_data_t rt_data,
    output logic                        rt_illegal,
    input  logic                        rt_ready,
    output logic                        wr_vxsat_valid,
    output logic                        wr_vxsat
);

    // Queue to dispatch
    logic                        cq_valid;
    vec_backend_pkg::inst_t      cq_inst;
    logic                        cq_ready;
    // Register file read
    vec_backend_pkg::vreg_idx_t  rd_idx_a;
    vec_backend_pkg::vreg_idx_t  rd_idx_b;
    vec_backend_pkg::vreg_data_t rd_data_a;
    vec_backend_pkg::vreg_data_t rd_data_b;
    // Dispatch to ALU
    logic                        ex_valid;
    vec_backend_pkg::alu_op_t    ex_op;
    vec_backend_pkg::vreg_idx_t  ex_vd;
    vec_backend_pkg::vreg_data_t ex_src_a;
    vec_backend_pkg::vreg_data_t ex_src_b;
    logic                        ex_ready;
    // ALU to ROB
    logic                        res_valid;
    vec_backend_pkg::vreg_idx_t  res_vd;
    vec_backend_pkg::vreg_data_t res_data;
    logic [1:0]                  res_vxsat;
    logic                        res_illegal;
    logic                        res_ready;
    // Retire write back
    logic                        wr_en;
    vec_backend_pkg::vreg_idx_t  wr_vd;
    vec_backend_pkg::vreg_data_t wr_data;

    vec_cmd_queue cmd_queue_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_ready (inst_ready),
        .cq_valid   (cq_valid),
        .cq_inst    (cq_inst),
        .cq_ready   (cq_ready)
    );

    vec_dispatch dispatch_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .cq_valid  (cq_valid),
        .cq_inst   (cq_inst),
        .cq_ready  (cq_ready),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .ex_valid  (ex_valid),
        .ex_op     (ex_op),
        .ex_vd     (ex_vd),
        .ex_src_a  (ex_src_a),
        .ex_src_b  (ex_src_b),
        .ex_ready  (ex_ready),
        .wr_en     (wr_en),
        .wr_vd     (wr_vd)
    );

    vec_vrf vrf_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd_idx_a  (rd_idx_a),
        .rd_idx_b  (rd_idx_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wr_en),
        .wr_vd     (wr_vd),
        .wr_data   (wr_data)
    );

    vec_alu alu_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_valid    (ex_valid),
        .ex_op       (ex_op),
        .ex_vd       (ex_vd),
        .ex_src_a    (ex_src_a),
        .ex_src_b    (ex_src_b),
        .ex_ready    (ex_ready),
        .res_valid   (res_valid),
        .res_vd      (res_vd),
        .res_data    (res_data),
        .res_vxsat   (res_vxsat),
        .res_illegal (res_illegal),
        .res_ready   (res_ready)
    );

    vec_rob rob_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .res_valid      (res_valid),
        .res_vd         (res_vd),
        .res_data       (res_data),
        .res_vxsat      (res_vxsat),
        .res_illegal    (res_illegal),
        .res_ready      (res_ready),
        .rt_valid       (rt_valid),
        .rt_vd          (rt_vd),
        .rt_data        (rt_data),
        .rt_illegal     (rt_illegal),
        .rt_ready       (rt_ready),
        .wr_vxsat_valid (wr_vxsat_valid),
        .wr_vxsat       (wr_vxsat),
        .wr_en          (wr_en),
        .wr_vd          (wr_vd),
        .wr_data        (wr_data)
    );

endmodule

/* tb_vec_backend.sv */
`timescale 1ns/100ps
`include "vec_backend_cfg.svh"

module tb_vec_backend;

    logic                        clk;
    logic                        rst_n;
    logic                        inst_valid;
    vec_backend_pkg::inst_t      inst;
    logic                        inst_ready;
    logic                        rt_valid;
    vec_backend_pkg::vreg_idx_t  rt_vd;
    vec_backend_pkg::vreg_data_t rt_data;
    logic                        rt_illegal;
    logic                        rt_ready;
    logic                        wr_vxsat_valid;
    logic                        wr_vxsat;

    // Reference state and expected retire stream
    vec_backend_pkg::vreg_data_t model_vrf [`NUM_VREG];
    vec_backend_pkg::vreg_idx_t  exp_vd [$];
    vec_backend_pkg::vreg_data_t exp_data [$];
    logic                        exp_illegal [$];
    logic                        exp_sat_valid [$];
    logic                        exp_sat [$];
    vec_backend_pkg::vreg_data_t last_rt_data;
    logic [31:0]                 lfsr_state = 32'h9acd19fe;
    int                          n;
    vec_backend_pkg::vreg_idx_t  prev_vd;
    vec_backend_pkg::vreg_idx_t  next_vd;

    vec_backend vec_backend_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .inst_ready     (inst_ready),
        .rt_valid       (rt_valid),
        .rt_vd          (rt_vd),
        .rt_data        (rt_data),
        .rt_illegal     (rt_illegal),
        .rt_ready       (rt_ready),
        .wr_vxsat_valid (wr_vxsat_valid),
        .wr_vxsat       (wr_vxsat)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else abort_run($sformatf("ERR %s got %0h expected %0h", name, got, exp));
    endtask

    // Galois LFSR, one step per bit
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] v;
        logic        lsb;
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lsb = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (lsb) begin
                lfsr_state = lfsr_state ^ 32'h80200003;
            end
            v = {v[30:0], lsb};
        end
        return v;
    endfunction

    function automatic vec_backend_pkg::inst_t make_vv(input logic [5:0] f6,
            input logic [4:0] vs2, input logic [4:0] vs1, input logic [4:0] vd);
        return {f6, 1'b1, vs2, vs1, `FUNCT3_OPIVV, vd, `OPCODE_OPV};
    endfunction

    function automatic vec_backend_pkg::inst_t random_op();
        logic [1:0] sel;
        logic [5:0] f6;
        sel = rand_bits(2);
        f6 = (sel == 2'd1) ? `FUNCT6_VSUB : (sel[1] ? `FUNCT6_VAND : `FUNCT6_VADD);
        return make_vv(f6, rand_bits(5), rand_bits(5), rand_bits(5));
    endfunction

    // Program-order result, pushed for the retire monitor
    task automatic model_issue(input vec_backend_pkg::inst_t w);
        logic [5:0]                  f6;
        vec_backend_pkg::vreg_data_t a;
        vec_backend_pkg::vreg_data_t b;
        vec_backend_pkg::vreg_data_t r;
        logic                        legal;
        logic                        sat;
        int                          ea;
        int                          eb;
        f6 = w[31:26];
        a = model_vrf[w[24:20]];
        b = model_vrf[w[19:15]];
        r = '0;
        sat = 1'b0;
        legal = (w[6:0] == `OPCODE_OPV) && (w[14:12] == `FUNCT3_OPIVV) &&
                (f6 inside {`FUNCT6_VADD, `FUNCT6_VSUB, `FUNCT6_VAND, `FUNCT6_VSADDU});
        for (int l = 0; l < `VLEN / `ELEN; l++) begin
            ea = a[l*8 +: 8];
            eb = b[l*8 +: 8];
            if (f6 == `FUNCT6_VADD) begin
                r[l*8 +: 8] = 8'((ea + eb) % 256);
            end else if (f6 == `FUNCT6_VSUB) begin
                r[l*8 +: 8] = 8'((ea - eb + 256) % 256);
            end else if (f6 == `FUNCT6_VAND) begin
                r[l*8 +: 8] = 8'(ea & eb);
            end else if (ea + eb > 255) begin
                r[l*8 +: 8] = 8'd255;
                sat = 1'b1;
            end else begin
                r[l*8 +: 8] = 8'(ea + eb);
            end
        end
        if (legal) begin
            model_vrf[w[11:7]] = r;
        end
        exp_vd.push_back(w[11:7]);
        exp_data.push_back(legal ? r : '0);
        exp_illegal.push_back(!legal);
        exp_sat_valid.push_back(legal && f6 == `FUNCT6_VSADDU);
        exp_sat.push_back(sat);
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic send(input vec_backend_pkg::inst_t w);
        int waited;
        waited = 0;
        inst_valid = 1'b1;
        inst = w;
        while (!inst_ready) begin
            @(negedge clk);
            waited++;
            if (waited > 100) abort_run("instruction was not accepted in time");
        end
        model_issue(w);
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_vd.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > 400) abort_run("outstanding results did not retire in time");
        end
    endtask

    // Retire monitor against the expected stream
    always @(posedge clk) begin
        if (rst_n && rt_valid && rt_ready) begin
            assert (exp_vd.size() > 0)
            else abort_run("a result retired with no instruction outstanding");
            check_value("rt_vd", rt_vd, exp_vd[0]);
            check_value("rt_data", rt_data, exp_data[0]);
            check_value("rt_illegal", rt_illegal, exp_illegal[0]);
            check_value("wr_vxsat_valid", wr_vxsat_valid, exp_sat_valid[0]);
            if (exp_sat_valid[0]) begin
                check_value("wr_vxsat", wr_vxsat, exp_sat[0]);
            end
            last_rt_data = rt_data;
            void'(exp_vd.pop_front());
            void'(exp_data.pop_front());
            void'(exp_illegal.pop_front());
            void'(exp_sat_valid.pop_front());
            void'(exp_sat.pop_front());
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        rt_valid && !rt_ready |=> rt_valid && $stable(rt_vd) && $stable(rt_data))
    else abort_run("retire port changed while stalled");

    assert property (@(posedge clk) disable iff (!rst_n)
        wr_vxsat_valid |-> rt_valid && rt_ready)
    else abort_run("vxsat update outside a retire handshake");

    initial begin
        rst_n = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        rt_ready = 1'b1;
        for (int i = 0; i < `NUM_VREG; i++) begin
            model_vrf[i] = {8{i[7:0]}};
        end
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        check_value("rt_valid", rt_valid, 1'b0);
        check_value("wr_vxsat_valid", wr_vxsat_valid, 1'b0);
        check_value("inst_ready", inst_ready, 1'b1);

        // Index pattern read back, then v7 = v3 + v5
        for (int i = 0; i < `NUM_VREG; i++) begin
            send(make_vv(`FUNCT6_VAND, i[4:0], i[4:0], i[4:0]));
        end
        send(make_vv(`FUNCT6_VADD, 5'd5, 5'd3, 5'd7));
        wait_drain();
        check_value("rt_data", last_rt_data, 64'h0808080808080808);

        // v20 = 0 - 1 gives FF lanes to saturate on
        send(make_vv(`FUNCT6_VSUB, 5'd0, 5'd1, 5'd20));
        send(make_vv(`FUNCT6_VSADDU, 5'd20, 5'd2, 5'd21));
        send(make_vv(`FUNCT6_VSADDU, 5'd3, 5'd4, 5'd22));
        wait_drain();

        // Bad funct6 into v5, bad opcode into v6, then read both
        send({6'b111111, 1'b1, 5'd1, 5'd2, `FUNCT3_OPIVV, 5'd5, `OPCODE_OPV});
        send({`FUNCT6_VADD, 1'b1, 5'd1, 5'd2, `FUNCT3_OPIVV, 5'd6, 7'b0100111});
        send(make_vv(`FUNCT6_VAND, 5'd5, 5'd5, 5'd9));
        send(make_vv(`FUNCT6_VAND, 5'd6, 5'd6, 5'd10));
        wait_drain();

        repeat (40) send(random_op());
        wait_drain();

        // Each instruction reads the previous destination
        prev_vd = 5'd7;
        repeat (16) begin
            next_vd = rand_bits(5);
            send(make_vv(random_op() >> 26, prev_vd, rand_bits(5), next_vd));
            prev_vd = next_vd;
        end
        wait_drain();

        // Retire stalled until the issue port pushes back
        rt_ready = 1'b0;
        n = 0;
        while (inst_ready) begin
            if (n >= 32) abort_run("inst_ready never dropped under back-pressure");
            send(random_op());
            n++;
        end
        repeat (4) @(negedge clk);
        check_value("inst_ready", inst_ready, 1'b0);
        rt_ready = 1'b1;
        wait_drain();

        // Nothing more may come out once the expected stream is empty
        repeat (4) @(negedge clk);
        if (rt_valid === 1'b0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            abort_run($sformatf("ERR rt_valid got %0h expected 0", rt_valid));
        end
    end

endmodule

/* vec_backend.f */
+incdir+.
vec_backend_pkg.sv
vec_cmd_queue.sv
vec_dispatch.sv
vec_vrf.sv
vec_alu.sv
vec_rob.sv
vec_backend.sv
tb_vec_backend.sv

/* Bender.yml */
package:
  name: vec_backend

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - vec_backend_pkg.sv
      - vec_cmd_queue.sv
      - vec_dispatch.sv
      - vec_vrf.sv
      - vec_alu.sv
      - vec_rob.sv
      - vec_backend.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_vec_backend.sv
